// File: sources.f
rtl/pq_cmd_pkg.sv
rtl/pq_ctrl_pkg.sv
rtl/pq_cmd_rx.sv
rtl/pq_control_fsm.sv
rtl/pq_datapath.sv
rtl/pq_slot_ram.sv
rtl/pq_resp_tx.sv
rtl/pq_top.sv
verif/pq_tb.sv

// File: verif/pq_tb.sv
`timescale 1ns/1ps

module pq_tb
  import pq_cmd_pkg::*;
();

  localparam int DATA_W = 16;
  localparam int DEPTH  = 8;
  localparam int N_CMDS = 250;  // 1 + 16 + 17 + 16 + 200
  localparam int LIMIT  = 16 + N_CMDS * (4 * DEPTH + 30);
  localparam logic [31:0] SEED = 32'h3f83_f151;

  logic              clk = 1'b0;
  logic              rst;
  logic              cmd_req;
  pq_op_t            cmd_op;
  logic [DATA_W-1:0] cmd_key;
  logic              resp_ack;
  logic              cmd_ack;
  logic              resp_req;
  pq_status_t        resp_status;
  logic [DATA_W-1:0] resp_key;

  logic [DATA_W-1:0] model [DEPTH];       // Sorted, smallest at index 0
  int                model_cnt = 0;
  pq_status_t        exp_st_q [$];
  logic [DATA_W-1:0] exp_key_q [$];
  bit                exp_chk_q [$];       // Key checked on dequeues only
  pq_status_t        exp_st;
  logic [DATA_W-1:0] exp_key;
  bit                exp_chk;
  int                issued = 0;
  int                resp_count = 0;
  int                cycles = 0;
  logic [31:0]       host_rng = SEED;
  logic [31:0]       resp_rng = SEED ^ 32'h5a5a_a5a5;

  pq_top #(.DATA_W(DATA_W), .DEPTH(DEPTH)) pq_top_i
  (
    .clk         (clk),
    .rst         (rst),
    .cmd_req     (cmd_req),
    .cmd_op      (cmd_op),
    .cmd_key     (cmd_key),
    .resp_ack    (resp_ack),
    .cmd_ack     (cmd_ack),
    .resp_req    (resp_req),
    .resp_status (resp_status),
    .resp_key    (resp_key)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] draw_host();
    host_rng = xorshift32(host_rng);
    return host_rng;
  endfunction

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic void predict(input pq_op_t op, input logic [DATA_W-1:0] key,
                                  output pq_status_t st, output logic [DATA_W-1:0] k);
    int pos;
    st  = ST_OK;
    k   = '0;
    pos = model_cnt;
    if (op == OP_ENQ)
    begin
      if (model_cnt == DEPTH)
        st = ST_FULL;
      else
      begin
        while (pos > 0 && model[pos-1] > key)  // Equal keys keep arrival order
        begin
          model[pos] = model[pos-1];
          pos--;
        end
        model[pos] = key;
        model_cnt++;
      end
    end
    else if (model_cnt == 0)
      st = ST_EMPTY;
    else
    begin
      k = model[0];
      for (pos = 1; pos < model_cnt; pos++)
        model[pos-1] = model[pos];
      model_cnt--;
    end
  endfunction

  task automatic abort_run();
    $display("Something failed");
    $fatal(1, "Stopped at first error");
  endtask

  // Host side of the command handshake
  task automatic send_cmd(input pq_op_t op, input logic [DATA_W-1:0] key);
    pq_status_t        st;
    logic [DATA_W-1:0] k;
    int                gap;
    predict(op, key, st, k);
    exp_st_q.push_back(st);
    exp_key_q.push_back(k);
    exp_chk_q.push_back(op == OP_DEQ);
    gap = int'(draw_host() & 32'h3);
    repeat (gap) @(posedge clk);
    @(posedge clk);
    cmd_req <= 1'b1;
    cmd_op  <= op;
    cmd_key <= key;
    do @(posedge clk); while (!cmd_ack);
    cmd_req <= 1'b0;
    do @(posedge clk); while (cmd_ack);
    issued++;
  endtask

  ////////////////////////////////////////
  // Response agent and compare
  ////////////////////////////////////////

  always
  begin
    @(posedge clk);
    if (resp_req)
    begin
      assert (exp_st_q.size() > 0) else
      begin
        $display("A response arrived with no command outstanding");
        abort_run();
      end
      exp_st  = exp_st_q.pop_front();
      exp_key = exp_key_q.pop_front();
      exp_chk = exp_chk_q.pop_front();
      assert (resp_status == exp_st) else
      begin
        $display("ERROR resp_status: got %h, expected %h", resp_status, exp_st);
        abort_run();
      end
      if (exp_chk)
      begin
        assert (resp_key == exp_key) else
        begin
          $display("ERROR resp_key: got %h, expected %h", resp_key, exp_key);
          abort_run();
        end
      end
      resp_rng = xorshift32(resp_rng);
      repeat (int'(resp_rng[1:0])) @(posedge clk);  // Host ack delay
      resp_ack <= 1'b1;
      do @(posedge clk); while (resp_req);
      resp_ack <= 1'b0;
      resp_count++;
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= LIMIT)
    begin
      $display("The run timed out after %0d cycles with responses still missing", cycles);
      abort_run();
    end
  end

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial
  begin
    logic [31:0]       r;
    pq_op_t            op;
    logic [DATA_W-1:0] key;
    rst      = 1'b1;
    cmd_req  = 1'b0;
    cmd_op   = OP_ENQ;
    cmd_key  = '0;
    resp_ack = 1'b0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    send_cmd(OP_DEQ, '0);  // Empty right after reset
    for (int i = 0; i < 8; i++)
      send_cmd(OP_ENQ, DATA_W'(draw_host() >> 16));
    for (int i = 0; i < 8; i++)
      send_cmd(OP_DEQ, '0);
    for (int i = 0; i < 9; i++)
      send_cmd(OP_ENQ, DATA_W'(draw_host() >> 16));  // Last one hits a full queue
    for (int i = 0; i < 8; i++)
      send_cmd(OP_DEQ, '0);

    // Duplicates and both extremes
    send_cmd(OP_ENQ, 16'h0005);
    send_cmd(OP_ENQ, 16'hffff);
    send_cmd(OP_ENQ, 16'h0000);
    send_cmd(OP_ENQ, 16'h0005);
    send_cmd(OP_ENQ, 16'hffff);
    send_cmd(OP_ENQ, 16'h0000);
    send_cmd(OP_ENQ, 16'h0007);
    send_cmd(OP_ENQ, 16'h0005);
    for (int i = 0; i < 8; i++)
      send_cmd(OP_DEQ, '0);

    for (int i = 0; i < 200; i++)
    begin
      r   = draw_host();
      op  = r[0] ? OP_DEQ : OP_ENQ;
      key = r[8] ? r[31:16] : {12'h000, r[23:20]};  // Small keys give duplicates
      send_cmd(op, key);
    end

    while (resp_count < issued)
      @(posedge clk);
    $display("Everything OK");
    $finish;
  end

endmodule

// File: rtl/pq_top.sv
`timescale 1ns/1ps

module pq_top
  import pq_cmd_pkg::*;
  import pq_ctrl_pkg::*;
#(
  parameter int DATA_W = 16,
  parameter int DEPTH  = 8
)
(
  input  logic              clk,
  input  logic              rst,
  input  logic              cmd_req,
  input  pq_op_t            cmd_op,
  input  logic [DATA_W-1:0] cmd_key,
  input  logic              resp_ack,
  output logic              cmd_ack,
  output logic              resp_req,
  output pq_status_t        resp_status,
  output logic [DATA_W-1:0] resp_key
);

  localparam int IDX_W = $clog2(DEPTH);

  logic              pend;
  pq_op_t            pend_op;
  logic [DATA_W-1:0] pend_key;
  logic              take;
  logic              full;
  logic              empty;
  logic              at_tail;
  logic              at_head;
  logic              key_less;
  reg_mode_t         reg_mode;
  idx_op_t           idx_op;
  logic              idx_dir;
  logic              cnt_inc;
  logic              cnt_dec;
  logic              resp_load;
  pq_status_t        fsm_status;
  logic              tx_free;
  logic [DATA_W-1:0] held_key;
  logic [IDX_W-1:0]  rd_addr;
  logic [IDX_W-1:0]  wr_addr;
  logic              wr_en;
  logic [DATA_W-1:0] wr_data;
  logic [DATA_W-1:0] rd_data;

  pq_cmd_rx #(.DATA_W(DATA_W)) pq_cmd_rx_i
  (
    .clk      (clk),
    .rst      (rst),
    .cmd_req  (cmd_req),
    .cmd_op   (cmd_op),
    .cmd_key  (cmd_key),
    .take     (take),
    .cmd_ack  (cmd_ack),
    .pend     (pend),
    .pend_op  (pend_op),
    .pend_key (pend_key)
  );

  pq_control_fsm pq_control_fsm_i
  (
    .clk         (clk),
    .rst         (rst),
    .pend        (pend),
    .pend_op     (pend_op),
    .full        (full),
    .empty       (empty),
    .at_tail     (at_tail),
    .at_head     (at_head),
    .key_less    (key_less),
    .tx_free     (tx_free),
    .take        (take),
    .reg_mode    (reg_mode),
    .idx_op      (idx_op),
    .idx_dir     (idx_dir),
    .cnt_inc     (cnt_inc),
    .cnt_dec     (cnt_dec),
    .resp_load   (resp_load),
    .resp_status (fsm_status)
  );

  pq_datapath #(.DATA_W(DATA_W), .DEPTH(DEPTH)) pq_datapath_i
  (
    .clk      (clk),
    .rst      (rst),
    .pend_key (pend_key),
    .reg_mode (reg_mode),
    .idx_op   (idx_op),
    .idx_dir  (idx_dir),
    .cnt_inc  (cnt_inc),
    .cnt_dec  (cnt_dec),
    .rd_data  (rd_data),
    .held_key (held_key),
    .full     (full),
    .empty    (empty),
    .at_tail  (at_tail),
    .at_head  (at_head),
    .key_less (key_less),
    .rd_addr  (rd_addr),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data)
  );

  pq_slot_ram #(.DATA_W(DATA_W), .DEPTH(DEPTH)) pq_slot_ram_i
  (
    .clk     (clk),
    .rd_addr (rd_addr),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_data (rd_data)
  );

  pq_resp_tx #(.DATA_W(DATA_W)) pq_resp_tx_i
  (
    .clk         (clk),
    .rst         (rst),
    .resp_load   (resp_load),
    .status_in   (fsm_status),
    .key_in      (held_key),
    .resp_ack    (resp_ack),
    .tx_free     (tx_free),
    .resp_req    (resp_req),
    .resp_status (resp_status),
    .resp_key    (resp_key)
  );

endmodule

// File: rtl/pq_resp_tx.sv
`timescale 1ns/1ps

module pq_resp_tx
  import pq_cmd_pkg::*;
#(
  parameter int DATA_W = 16
)
(
  input  logic              clk,
  input  logic              rst,
  input  logic              resp_load,
  input  pq_status_t        status_in,
  input  logic [DATA_W-1:0] key_in,
  input  logic              resp_ack,
  output logic              tx_free,
  output logic              resp_req,
  output pq_status_t        resp_status,
  output logic [DATA_W-1:0] resp_key
);

  typedef enum logic [1:0]
  {
    TX_FREE     = 2'd0,
    TX_REQ      = 2'd1,  // Req high, wait for ack
    TX_WAIT_LOW = 2'd2   // Req dropped, wait for ack to fall
  } tx_state_t;

  tx_state_t state;

  assign tx_free  = (state == TX_FREE);
  assign resp_req = (state == TX_REQ);

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= TX_FREE;
    else
    begin
      case (state)
        TX_FREE:     if (resp_load) state <= TX_REQ;
        TX_REQ:      if (resp_ack) state <= TX_WAIT_LOW;
        TX_WAIT_LOW: if (!resp_ack) state <= TX_FREE;
        default:     state <= TX_FREE;
      endcase
    end
  end

  // Response payload, stable while req is high
  always_ff @(posedge clk)
  begin
    if (tx_free && resp_load)
    begin
      resp_status <= status_in;
      resp_key    <= (status_in == ST_OK) ? key_in : '0;  // Failures carry zero
    end
  end

endmodule

// File: rtl/pq_slot_ram.sv
`timescale 1ns/1ps

module pq_slot_ram
#(
  parameter int DATA_W = 16,
  parameter int DEPTH  = 8
)
(
  input  logic                     clk,
  input  logic [$clog2(DEPTH)-1:0] rd_addr,
  input  logic                     wr_en,
  input  logic [$clog2(DEPTH)-1:0] wr_addr,
  input  logic [DATA_W-1:0]        wr_data,
  output logic [DATA_W-1:0]        rd_data
);

  logic [DATA_W-1:0] mem [DEPTH];

  // Read before write on a shared address
  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_addr] <= wr_data;
    rd_data <= mem[rd_addr];  // One cycle read
  end

endmodule

// File: rtl/pq_datapath.sv
`timescale 1ns/1ps

module pq_datapath
  import pq_ctrl_pkg::*;
#(
  parameter int DATA_W = 16,
  parameter int DEPTH  = 8
)
(
  input  logic                     clk,
  input  logic                     rst,
  input  logic [DATA_W-1:0]        pend_key,
  input  reg_mode_t                reg_mode,
  input  idx_op_t                  idx_op,
  input  logic                     idx_dir,
  input  logic                     cnt_inc,
  input  logic                     cnt_dec,
  input  logic [DATA_W-1:0]        rd_data,
  output logic [DATA_W-1:0]        held_key,
  output logic                     full,
  output logic                     empty,
  output logic                     at_tail,
  output logic                     at_head,
  output logic                     key_less,
  output logic [$clog2(DEPTH)-1:0] rd_addr,
  output logic                     wr_en,
  output logic [$clog2(DEPTH)-1:0] wr_addr,
  output logic [DATA_W-1:0]        wr_data
);

  localparam int IDX_W = $clog2(DEPTH);
  localparam logic [IDX_W:0] CNT_MAX = (IDX_W+1)'(DEPTH);

  logic [IDX_W-1:0] idx;     // Walk position
  logic [IDX_W:0]   cnt;     // Valid slots, one wider to reach DEPTH
  logic [IDX_W:0]   cnt_m1;

  assign cnt_m1 = cnt - 1'b1;

  ////////////////////////////////////////
  // Index and occupancy
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      idx <= '0;
      cnt <= '0;
    end
    else
    begin
      case (idx_op)
        IX_CLEAR:     idx <= '0;
        IX_LOAD_TAIL: idx <= cnt_m1[IDX_W-1:0];
        IX_INC_DEC:   idx <= idx_dir ? idx + 1'b1 : idx - 1'b1;
        default:      idx <= idx;
      endcase
      if (cnt_inc)
        cnt <= cnt + 1'b1;
      else if (cnt_dec)
        cnt <= cnt - 1'b1;
    end
  end

  // Held key, payload only
  always_ff @(posedge clk)
  begin
    case (reg_mode)
      RM_LOAD_CMD: held_key <= pend_key;
      RM_LOAD_MAX: held_key <= '1;      // Sorts after every real key
      RM_SWAP:     held_key <= rd_data;
      default:     held_key <= held_key;
    endcase
  end

  ////////////////////////////////////////
  // Flags and RAM access
  ////////////////////////////////////////

  assign full     = (cnt == CNT_MAX);
  assign empty    = (cnt == '0);
  assign at_tail  = ({1'b0, idx} == cnt);  // First unused slot
  assign at_head  = (idx == '0);
  assign key_less = (held_key < rd_data);

  assign rd_addr = idx;
  assign wr_addr = idx;
  assign wr_data = held_key;               // Slot always takes the old held key
  assign wr_en   = (reg_mode == RM_SWAP) || (reg_mode == RM_KEEP_WRITE);

endmodule

// File: rtl/pq_control_fsm.sv
`timescale 1ns/1ps

module pq_control_fsm
  import pq_cmd_pkg::*;
  import pq_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       pend,
  input  pq_op_t     pend_op,
  input  logic       full,
  input  logic       empty,
  input  logic       at_tail,
  input  logic       at_head,
  input  logic       key_less,
  input  logic       tx_free,
  output logic       take,
  output reg_mode_t  reg_mode,
  output idx_op_t    idx_op,
  output logic       idx_dir,
  output logic       cnt_inc,
  output logic       cnt_dec,
  output logic       resp_load,
  output pq_status_t resp_status
);

  typedef enum logic [3:0]
  {
    IDLE        = 4'd0,
    ENQ_FILL    = 4'd1,
    ENQ_READ    = 4'd2,
    ENQ_COMPARE = 4'd3,
    ENQ_STEP    = 4'd4,
    ENQ_PLACE   = 4'd5,
    DEQ_FILL    = 4'd6,
    DEQ_READ    = 4'd7,
    DEQ_SWAP    = 4'd8,
    DEQ_STEP    = 4'd9,
    RESPOND     = 4'd10
  } state_t;

  state_t     state;
  state_t     next;
  pq_status_t status_q;
  pq_status_t status_d;

  assign resp_status = status_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state    <= IDLE;
      status_q <= ST_OK;
    end
    else
    begin
      state    <= next;
      status_q <= status_d;
    end
  end

  ////////////////////////////////////////
  // Next state and datapath controls
  ////////////////////////////////////////

  always_comb
  begin
    next      = state;
    status_d  = status_q;
    take      = 1'b0;
    reg_mode  = RM_HOLD;
    idx_op    = IX_HOLD;
    idx_dir   = 1'b0;
    cnt_inc   = 1'b0;
    cnt_dec   = 1'b0;
    resp_load = 1'b0;

    case (state)
      IDLE:
      begin
        if (pend)
        begin
          take = 1'b1;
          if (pend_op == OP_ENQ)
          begin
            if (full)
            begin
              status_d = ST_FULL;  // Reject without touching the RAM
              next     = RESPOND;
            end
            else
              next = ENQ_FILL;
          end
          else if (empty)
          begin
            status_d = ST_EMPTY;
            next     = RESPOND;
          end
          else
            next = DEQ_FILL;
        end
      end

      // Enqueue walks up from slot 0, smaller key stays, larger moves on
      ENQ_FILL:
      begin
        reg_mode = RM_LOAD_CMD;
        idx_op   = IX_CLEAR;
        next     = empty ? ENQ_PLACE : ENQ_READ;
      end
      ENQ_READ:
        next = ENQ_COMPARE;  // Slot 0 read in flight
      ENQ_COMPARE:
      begin
        if (key_less)
          reg_mode = RM_SWAP;  // Held key belongs here
        idx_op  = IX_INC_DEC;
        idx_dir = 1'b1;
        next    = ENQ_STEP;
      end
      ENQ_STEP:
        next = at_tail ? ENQ_PLACE : ENQ_COMPARE;  // Next slot read in flight
      ENQ_PLACE:
      begin
        reg_mode = RM_KEEP_WRITE;  // Carried key into the empty slot
        cnt_inc  = 1'b1;
        status_d = ST_OK;
        next     = RESPOND;
      end

      // Dequeue walks down from the tail, every entry shifts toward the head
      DEQ_FILL:
      begin
        reg_mode = RM_LOAD_MAX;
        idx_op   = IX_LOAD_TAIL;
        next     = DEQ_READ;
      end
      DEQ_READ:
        next = DEQ_SWAP;
      DEQ_SWAP:
      begin
        reg_mode = RM_SWAP;
        if (at_head)
        begin
          cnt_dec  = 1'b1;  // Head key now in held register
          status_d = ST_OK;
          next     = RESPOND;
        end
        else
        begin
          idx_op = IX_INC_DEC;
          next   = DEQ_STEP;
        end
      end
      DEQ_STEP:
        next = DEQ_SWAP;

      RESPOND:
      begin
        if (tx_free)
        begin
          resp_load = 1'b1;
          next      = IDLE;
        end
      end

      default: next = IDLE;
    endcase
  end

endmodule

// File: rtl/pq_cmd_rx.sv
`timescale 1ns/1ps

module pq_cmd_rx
  import pq_cmd_pkg::*;
#(
  parameter int DATA_W = 16
)
(
  input  logic              clk,
  input  logic              rst,
  input  logic              cmd_req,
  input  pq_op_t            cmd_op,
  input  logic [DATA_W-1:0] cmd_key,
  input  logic              take,
  output logic              cmd_ack,
  output logic              pend,
  output pq_op_t            pend_op,
  output logic [DATA_W-1:0] pend_key
);

  typedef enum logic [1:0]
  {
    RX_WAIT_REQ     = 2'd0,
    RX_ACKED        = 2'd1,  // Ack high until host drops req
    RX_WAIT_RELEASE = 2'd2   // Handshake done, command not yet taken
  } rx_state_t;

  rx_state_t state;

  assign cmd_ack = (state == RX_ACKED);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= RX_WAIT_REQ;
      pend  <= 1'b0;
    end
    else
    begin
      if (take)
        pend <= 1'b0;  // FSM has started the command
      case (state)
        RX_WAIT_REQ:
        begin
          if (cmd_req)
          begin
            pend  <= 1'b1;
            state <= RX_ACKED;
          end
        end
        RX_ACKED:
        begin
          if (!cmd_req)
            state <= (pend && !take) ? RX_WAIT_RELEASE : RX_WAIT_REQ;
        end
        RX_WAIT_RELEASE:
        begin
          if (!pend || take)
            state <= RX_WAIT_REQ;  // Slot free again
        end
        default: state <= RX_WAIT_REQ;
      endcase
    end
  end

  // Command payload, written only on capture
  always_ff @(posedge clk)
  begin
    if (state == RX_WAIT_REQ && cmd_req)
    begin
      pend_op  <= cmd_op;
      pend_key <= cmd_key;
    end
  end

endmodule

// File: rtl/pq_ctrl_pkg.sv
package pq_ctrl_pkg;

  ////////////////////////////////////////
  // FSM to datapath controls
  ////////////////////////////////////////

  // What the held key register loads
  typedef enum logic [2:0]
  {
    RM_HOLD       = 3'd0,  // Keep value
    RM_LOAD_CMD   = 3'd1,  // Key from pending command
    RM_LOAD_MAX   = 3'd2,  // All ones, start of dequeue
    RM_SWAP       = 3'd3,  // Held key to slot, slot to held key
    RM_KEEP_WRITE = 3'd4   // Held key to slot only
  } reg_mode_t;

  // Walk index update
  typedef enum logic [1:0]
  {
    IX_HOLD      = 2'd0,
    IX_CLEAR     = 2'd1,  // Back to slot 0
    IX_LOAD_TAIL = 2'd2,  // Last valid slot
    IX_INC_DEC   = 2'd3   // Step, direction from idx_dir
  } idx_op_t;

endpackage

// File: rtl/pq_cmd_pkg.sv
package pq_cmd_pkg;

  ////////////////////////////////////////
  // Host command side
  ////////////////////////////////////////

  // Queue operation carried with each command
  typedef enum logic
  {
    OP_ENQ = 1'b0,  // Insert key
    OP_DEQ = 1'b1   // Remove smallest key
  } pq_op_t;

  // Status returned with every response
  typedef enum logic [1:0]
  {
    ST_OK    = 2'd0,
    ST_FULL  = 2'd1,  // Enqueue rejected
    ST_EMPTY = 2'd2   // Nothing to dequeue, key is zero
  } pq_status_t;

endpackage
